// File: Bender.yml
package:
  name: mic

export_include_dirs:
  - common

sources:
  - common/mic_pkg.sv
  - design/mic_ctrl.sv
  - design/loop_counter.sv
  - design/ir_operand_sel.sv
  - sequencer/addr_sel.sv
  - sequencer/ret_stack.sv
  - design/mic_top.sv
  - target: test
    files:
      - test/mic_assert.sv
      - test/mic_tb.sv

// File: common/mic_defines.svh
`ifndef MIC_DEFINES_SVH
`define MIC_DEFINES_SVH

// Microsequencer widths

`define MIC_MA_W 13 // Micro-address

`define MIC_LC_W 6 // Loop counter

`define MIC_RA_W 4 // Register file address

`define MIC_IR_W 7 // Instruction latch

`define MIC_CD_W 16 // Data bus and control word

// Return stack

`define MIC_STACK_DEPTH 4 // Default number of entries

`endif

// File: common/mic_pkg.sv
`default_nettype none

`include "mic_defines.svh"

package mic_pkg;

  typedef logic [`MIC_MA_W-1:0] maddr_t;  // Micro-address
  typedef logic [`MIC_LC_W-1:0] lcount_t; // Loop count
  typedef logic [`MIC_RA_W-1:0] raddr_t;  // Register file address
  typedef logic [`MIC_IR_W-1:0] ir_t;     // Latched instruction bits
  typedef logic [`MIC_CD_W-1:0] cdata_t;  // Data bus

  // Condition select codes
  // 0 zf, 1 cry, 2 ovf, 3 irq, 4 f11, 5 f15, 6 lcz, 7 always true
  typedef logic [2:0] cond_sel_t;

  typedef enum logic [2:0] {
    SEQ_CONT  = 3'd0,
    SEQ_JUMP  = 3'd1,
    SEQ_CJUMP = 3'd2,
    SEQ_CALL  = 3'd3,
    SEQ_RET   = 3'd4,
    SEQ_LOOP  = 3'd5 // Codes 6 and 7 act as continue
  } seq_op_t;

  typedef enum logic [1:0] {SRC_INC, SRC_TARGET, SRC_STACK} addr_src_t;

  typedef enum logic [1:0] {STK_HOLD, STK_POP, STK_PUSH} stack_op_t;

endpackage

`default_nettype wire

// File: design/ir_operand_sel.sv
`default_nettype none

`include "mic_defines.svh"

module ir_operand_sel (
  input  wire                   mclk,
  input  wire                   reset,
  input  wire                   ld_ir,
  input  wire mic_pkg::cdata_t  cd,
  input  wire [1:0]             rasel,
  input  wire [1:0]             rbsel,
  input  wire mic_pkg::raddr_t  a_lit,
  input  wire mic_pkg::raddr_t  csrb,
  input  wire mic_pkg::raddr_t  pil,
  input  wire mic_pkg::lcount_t lc,
  output mic_pkg::ir_t          ir,
  output mic_pkg::raddr_t       laa,
  output mic_pkg::raddr_t       lba
);

  mic_pkg::raddr_t laa_nxt;
  mic_pkg::raddr_t lba_nxt;

  // A operand source
  always_comb begin
    case (rasel)
      2'd0:    laa_nxt = a_lit;
      2'd1:    laa_nxt = pil;   // Interrupt level
      2'd2:    laa_nxt = ir[6:3];
      default: laa_nxt = lc[3:0];
    endcase
  end

  // B operand source
  always_comb begin
    case (rbsel)
      2'd0:    lba_nxt = csrb;
      2'd1:    lba_nxt = {1'b0, ir[2:0]};
      2'd2:    lba_nxt = {1'b0, ir[5:3]};
      default: lba_nxt = lc[3:0];
    endcase
  end

  always_ff @(posedge mclk) begin
    if (reset) begin
      ir  <= '0;
      laa <= '0;
      lba <= '0;
    end else begin
      if (ld_ir) ir <= cd[`MIC_IR_W-1:0];
      laa <= laa_nxt; // Uses ir before this edge
      lba <= lba_nxt;
    end
  end

endmodule

`default_nettype wire

// File: design/loop_counter.sv
`default_nettype none

module loop_counter (
  input  wire                   mclk,
  input  wire                   reset,
  input  wire                   ld_lc,
  input  wire mic_pkg::lcount_t load_val,
  input  wire                   lc_dec,
  output mic_pkg::lcount_t      lc,
  output logic                  lcz
);

  assign lcz = (lc == '0);

  // Load wins over decrement
  always_ff @(posedge mclk) begin
    if (reset) begin
      lc <= '0;
    end else if (ld_lc) begin
      lc <= load_val;
    end else if (lc_dec && !lcz) begin
      lc <= lc - 1'b1; // Stops at zero
    end
  end

endmodule

`default_nettype wire

// File: design/mic_ctrl.sv
`default_nettype none

module mic_ctrl (
  input  wire                     mclk,
  input  wire                     reset,
  input  wire mic_pkg::seq_op_t   seq_op,
  input  wire mic_pkg::cond_sel_t cond_sel,
  input  wire                     cond_inv,
  input  wire                     zf,
  input  wire                     cry,
  input  wire                     ovf,
  input  wire                     irq,
  input  wire                     f11,
  input  wire                     f15,
  input  wire                     lcz,
  output mic_pkg::addr_src_t      addr_src,
  output mic_pkg::stack_op_t      stack_op,
  output logic                    lc_dec,
  output logic                    cond
);

  logic flag;     // Flag picked by cond_sel
  logic cond_now; // Condition for this cycle's branch

  always_comb begin
    case (cond_sel)
      3'd0:    flag = zf;
      3'd1:    flag = cry;
      3'd2:    flag = ovf;
      3'd3:    flag = irq;
      3'd4:    flag = f11;
      3'd5:    flag = f15;
      3'd6:    flag = lcz;
      default: flag = 1'b1; // Always true
    endcase
  end

  assign cond_now = flag ^ cond_inv;

  // Sequencer op decode
  always_comb begin
    addr_src = mic_pkg::SRC_INC;
    stack_op = mic_pkg::STK_HOLD;
    lc_dec   = 1'b0;
    case (seq_op)
      mic_pkg::SEQ_JUMP: addr_src = mic_pkg::SRC_TARGET;
      mic_pkg::SEQ_CJUMP: begin
        if (cond_now) addr_src = mic_pkg::SRC_TARGET;
      end
      mic_pkg::SEQ_CALL: begin
        addr_src = mic_pkg::SRC_TARGET;
        stack_op = mic_pkg::STK_PUSH;
      end
      mic_pkg::SEQ_RET: begin
        addr_src = mic_pkg::SRC_STACK;
        stack_op = mic_pkg::STK_POP;
      end
      mic_pkg::SEQ_LOOP: begin
        // Branch back and count down until the counter runs out
        if (!lcz) begin
          addr_src = mic_pkg::SRC_TARGET;
          lc_dec   = 1'b1;
        end
      end
      default: ; // Continue
    endcase
  end

  always_ff @(posedge mclk) begin
    if (reset) begin
      cond <= 1'b0;
    end else begin
      cond <= cond_now; // Registered copy for the outside
    end
  end

endmodule

`default_nettype wire

// File: design/mic_top.sv
`default_nettype none

`include "mic_defines.svh"

module mic_top (
  input  wire                     mclk,
  input  wire                     reset,
  input  wire mic_pkg::seq_op_t   seq_op,
  input  wire mic_pkg::cdata_t    csbit,    // Jump field and A literal
  input  wire                     vect,
  input  wire mic_pkg::cond_sel_t cond_sel,
  input  wire                     cond_inv,
  input  wire                     zf,
  input  wire                     cry,
  input  wire                     ovf,
  input  wire                     irq,
  input  wire                     f11,
  input  wire                     f15,
  input  wire mic_pkg::cdata_t    cd,
  input  wire                     ld_lc,
  input  wire                     ld_ir,
  input  wire [1:0]               rasel,
  input  wire [1:0]               rbsel,
  input  wire mic_pkg::raddr_t    csrb,
  input  wire mic_pkg::raddr_t    pil,
  output mic_pkg::maddr_t         ma,
  output mic_pkg::raddr_t         laa,
  output mic_pkg::raddr_t         lba,
  output logic                    cond,
  output logic                    lcz,
  output logic                    deep
);

  mic_pkg::addr_src_t addr_src;
  mic_pkg::stack_op_t stack_op;
  logic               lc_dec;
  mic_pkg::maddr_t    ma_inc;    // Return address for calls
  mic_pkg::maddr_t    stack_top;
  mic_pkg::lcount_t   lc;
  mic_pkg::ir_t       ir;

  mic_ctrl ctrl_i (
    .mclk(mclk), .reset(reset), .seq_op(seq_op), .cond_sel(cond_sel),
    .cond_inv(cond_inv), .zf(zf), .cry(cry), .ovf(ovf), .irq(irq),
    .f11(f11), .f15(f15), .lcz(lcz), .addr_src(addr_src),
    .stack_op(stack_op), .lc_dec(lc_dec), .cond(cond)
  );

  addr_sel addr_sel_i (
    .mclk(mclk), .reset(reset), .addr_src(addr_src),
    .jmp_field(csbit[`MIC_MA_W-2:0]), .vect(vect), .ir(ir),
    .top(stack_top), .ma(ma), .ma_inc(ma_inc)
  );

  ret_stack ret_stack_i (
    .mclk(mclk), .reset(reset), .stack_op(stack_op),
    .push_addr(ma_inc), .top(stack_top), .deep(deep)
  );

  loop_counter loop_counter_i (
    .mclk(mclk), .reset(reset), .ld_lc(ld_lc),
    .load_val(cd[`MIC_LC_W-1:0]), .lc_dec(lc_dec), .lc(lc), .lcz(lcz)
  );

  ir_operand_sel ir_operand_sel_i (
    .mclk(mclk), .reset(reset), .ld_ir(ld_ir), .cd(cd),
    .rasel(rasel), .rbsel(rbsel), .a_lit(csbit[`MIC_CD_W-1:`MIC_CD_W-`MIC_RA_W]),
    .csrb(csrb), .pil(pil), .lc(lc), .ir(ir), .laa(laa), .lba(lba)
  );

endmodule

`default_nettype wire

// File: sequencer/addr_sel.sv
`default_nettype none

`include "mic_defines.svh"

module addr_sel (
  input  wire                     mclk,
  input  wire                     reset,
  input  wire mic_pkg::addr_src_t addr_src,
  input  wire [`MIC_MA_W-2:0]     jmp_field, // Low control word bits
  input  wire                     vect,
  input  wire mic_pkg::ir_t       ir,
  input  wire mic_pkg::maddr_t    top,       // Return address
  output mic_pkg::maddr_t         ma,
  output mic_pkg::maddr_t         ma_inc
);

  mic_pkg::maddr_t target;
  mic_pkg::maddr_t ma_nxt;

  assign ma_inc = ma + 1'b1;

  // Vectored jumps take the low nibble from the instruction
  always_comb begin
    target = {1'b0, jmp_field};
    if (vect) target[3:0] = ir[3:0];
  end

  always_comb begin
    case (addr_src)
      mic_pkg::SRC_TARGET: ma_nxt = target;
      mic_pkg::SRC_STACK:  ma_nxt = top;
      default:             ma_nxt = ma_inc;
    endcase
  end

  always_ff @(posedge mclk) begin
    if (reset) begin
      ma <= '0;
    end else begin
      ma <= ma_nxt;
    end
  end

endmodule

`default_nettype wire

// File: sequencer/ret_stack.sv
`default_nettype none

`include "mic_defines.svh"

module ret_stack #(
  parameter int DEPTH = `MIC_STACK_DEPTH
) (
  input  wire                     mclk,
  input  wire                     reset,
  input  wire mic_pkg::stack_op_t stack_op,
  input  wire mic_pkg::maddr_t    push_addr,
  output mic_pkg::maddr_t         top,
  output logic                    deep
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  mic_pkg::maddr_t  stk [DEPTH]; // Entry 0 is the top
  logic [CNT_W-1:0] cnt;         // Fill count

  assign top  = stk[0];
  assign deep = (cnt == CNT_W'(DEPTH));

  always_ff @(posedge mclk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        stk[i] <= '0;
      end
      cnt <= '0;
    end else begin
      case (stack_op)
        mic_pkg::STK_PUSH: begin
          stk[0] <= push_addr;
          for (int i = 1; i < DEPTH; i++) begin
            stk[i] <= stk[i-1]; // Bottom entry drops off
          end
          if (!deep) cnt <= cnt + 1'b1;
        end
        mic_pkg::STK_POP: begin
          for (int i = 0; i < DEPTH - 1; i++) begin
            stk[i] <= stk[i+1];
          end
          stk[DEPTH-1] <= '0; // Empty pop returns zero
          if (cnt != '0) cnt <= cnt - 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/mic_pkg.sv
design/mic_ctrl.sv
design/loop_counter.sv
design/ir_operand_sel.sv
sequencer/addr_sel.sv
sequencer/ret_stack.sv
design/mic_top.sv
test/mic_assert.sv
test/mic_tb.sv

// File: test/mic_assert.sv
`default_nettype none

`include "mic_defines.svh"

module mic_assert (
  input wire                                    mclk,
  input wire                                    reset,
  input wire mic_pkg::seq_op_t                  seq_op,
  input wire mic_pkg::maddr_t                   ma,
  input wire mic_pkg::maddr_t                   stack_top,
  input wire [$clog2(`MIC_STACK_DEPTH+1)-1:0]   stack_cnt,
  input wire mic_pkg::lcount_t                  lc,
  input wire                                    ld_lc,
  input wire                                    lcz,
  input wire                                    deep
);

  reset_clears: assert property (@(posedge mclk) $past(reset) |-> (ma == '0) && !deep)
    else $error("ma or deep not cleared by reset");

  // An empty stack holds only zeros
  empty_pop_zero: assert property (@(posedge mclk) disable iff (reset)
    (seq_op == mic_pkg::SEQ_RET && stack_cnt == '0) |-> (stack_top == '0))
    else $error("return from empty stack with nonzero top");

  // Only a load moves the counter away from zero
  lc_holds_at_zero: assert property (@(posedge mclk) disable iff (reset)
    (lcz && !ld_lc) |=> (lc == '0))
    else $error("loop count left zero without a load");

endmodule

bind mic_top mic_assert mic_assert_i (
  .mclk(mclk), .reset(reset), .seq_op(seq_op), .ma(ma), .stack_top(stack_top),
  .stack_cnt(ret_stack_i.cnt), .lc(lc), .ld_lc(ld_lc), .lcz(lcz), .deep(deep)
);

`default_nettype wire

// File: test/mic_tb.sv
`default_nettype none

`include "mic_defines.svh"

module mic_tb;

  localparam int TEST_CYCLES = 200;
  localparam int NUM_TESTS   = 5;
  localparam int MAX_CYCLES  = NUM_TESTS * TEST_CYCLES + 2 + 50; // Reset plus margin

  logic               mclk = 1'b0;
  logic               reset;
  mic_pkg::seq_op_t   seq_op;
  mic_pkg::cdata_t    csbit, cd;
  mic_pkg::cond_sel_t cond_sel;
  logic               vect, cond_inv, ld_lc, ld_ir;
  logic               zf, cry, ovf, irq, f11, f15;
  logic [1:0]         rasel, rbsel;
  mic_pkg::raddr_t    csrb, pil, laa, lba;
  mic_pkg::maddr_t    ma;
  logic               cond, lcz, deep;

  mic_pkg::maddr_t  m_ma = '0;
  mic_pkg::maddr_t  m_stk[$];   // Front is the top of stack
  mic_pkg::lcount_t m_lc = '0;
  mic_pkg::ir_t     m_ir = '0;
  mic_pkg::raddr_t  m_laa = '0;
  mic_pkg::raddr_t  m_lba = '0;
  logic             m_cond = 1'b0;
  logic [31:0]      lfsr = 32'h993b9b6e;
  int               cycles = 0;
  int               checks = 0;
  int               errors = 0;

  mic_top dut_i (.*);

  always #2 mclk = ~mclk;

  always @(posedge mclk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run went past %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0); // Galois taps 32,22,2,1
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], rand_bit()};
    return v;
  endfunction

  task automatic cmp_addr(input string name, input mic_pkg::maddr_t got, exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_reg(input string name, input mic_pkg::raddr_t got, exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_count(input string name, input mic_pkg::lcount_t got, exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic cmp_bit(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_outputs();
    cmp_addr("ma", ma, m_ma);
    cmp_reg("laa", laa, m_laa);
    cmp_reg("lba", lba, m_lba);
    cmp_count("lc", dut_i.lc, m_lc);
    cmp_bit("cond", cond, m_cond);
    cmp_bit("lcz", lcz, m_lc == '0);
    cmp_bit("deep", deep, m_stk.size() == `MIC_STACK_DEPTH);
  endtask

  // Advance the model by one clock using the inputs now applied
  task automatic model_step();
    mic_pkg::maddr_t target;
    mic_pkg::maddr_t next_seq;
    logic [7:0]      flags;
    logic            lc_zero;
    logic            taken;
    lc_zero  = (m_lc == '0);
    flags    = {1'b1, lc_zero, f15, f11, irq, ovf, cry, zf}; // Indexed by cond_sel
    taken    = flags[cond_sel] ^ cond_inv;
    next_seq = m_ma + 1'b1;
    target   = {1'b0, csbit[11:0]};
    if (vect) target[3:0] = m_ir[3:0];
    case (rasel)
      2'd0:    m_laa = csbit[15:12];
      2'd1:    m_laa = pil;
      2'd2:    m_laa = m_ir[6:3];
      default: m_laa = m_lc[3:0];
    endcase
    case (rbsel)
      2'd0:    m_lba = csrb;
      2'd1:    m_lba = {1'b0, m_ir[2:0]};
      2'd2:    m_lba = {1'b0, m_ir[5:3]};
      default: m_lba = m_lc[3:0];
    endcase
    case (seq_op)
      mic_pkg::SEQ_JUMP:  m_ma = target;
      mic_pkg::SEQ_CJUMP: m_ma = taken ? target : next_seq;
      mic_pkg::SEQ_CALL: begin
        m_stk.push_front(next_seq);
        if (m_stk.size() > `MIC_STACK_DEPTH) void'(m_stk.pop_back()); // Oldest lost
        m_ma = target;
      end
      mic_pkg::SEQ_RET:  m_ma = (m_stk.size() > 0) ? m_stk.pop_front() : '0;
      mic_pkg::SEQ_LOOP: m_ma = lc_zero ? next_seq : target;
      default:           m_ma = next_seq;
    endcase
    if (ld_lc) m_lc = cd[5:0];
    else if (seq_op == mic_pkg::SEQ_LOOP && !lc_zero) m_lc = m_lc - 1'b1;
    if (ld_ir) m_ir = cd[6:0];
    m_cond = taken;
  endtask

  task automatic drive_inputs(input int kind, input int cyc);
    mic_pkg::seq_op_t op;
    logic [1:0]       r;
    r = 2'(rand_bits(2));
    case (kind)
      1: op = r[0] ? mic_pkg::SEQ_JUMP : mic_pkg::SEQ_CONT;
      2: op = mic_pkg::SEQ_CJUMP;
      3: op = ((r != 2'd0) ^ ((cyc / 25) % 2 == 1)) ? mic_pkg::SEQ_CALL : mic_pkg::SEQ_RET;
      4: op = (r == 2'd0) ? mic_pkg::SEQ_CONT : mic_pkg::SEQ_LOOP;
      default: op = mic_pkg::SEQ_CONT;
    endcase
    @(posedge mclk);
    seq_op   <= op;
    csbit    <= 16'(rand_bits(16));
    cd       <= 16'(rand_bits(16));
    vect     <= rand_bit();
    cond_sel <= mic_pkg::cond_sel_t'(rand_bits(3));
    cond_inv <= rand_bit();
    {zf, cry, ovf, irq, f11, f15} <= 6'(rand_bits(6));
    ld_lc    <= (rand_bits(5) == 0); // Rare loads so loops can run out
    ld_ir    <= rand_bit();
    rasel    <= 2'(rand_bits(2));
    rbsel    <= 2'(rand_bits(2));
    csrb     <= mic_pkg::raddr_t'(rand_bits(4));
    pil      <= mic_pkg::raddr_t'(rand_bits(4));
  endtask

  task automatic run_test(input int kind, input string name);
    int errs_before;
    errs_before = errors;
    for (int cyc = 0; cyc < TEST_CYCLES; cyc++) begin
      check_outputs();
      model_step();
      drive_inputs(kind, cyc);
      @(negedge mclk);
    end
    $display("Test %0d, %s: %0d errors", kind, name, errors - errs_before);
  endtask

  initial begin
    reset    <= 1'b1;
    seq_op   <= mic_pkg::SEQ_CONT;
    csbit    <= '0;
    cd       <= '0;
    vect     <= 1'b0;
    cond_sel <= '0;
    cond_inv <= 1'b0;
    {zf, cry, ovf, irq, f11, f15} <= '0;
    ld_lc    <= 1'b0;
    ld_ir    <= 1'b0;
    rasel    <= '0;
    rbsel    <= '0;
    csrb     <= '0;
    pil      <= '0;
    repeat (2) @(posedge mclk);
    reset <= 1'b0;
    @(negedge mclk);
    run_test(1, "reset and sequencing");
    run_test(2, "conditional jumps");
    run_test(3, "call and return");
    run_test(4, "loops");
    run_test(5, "operand selection");
    check_outputs(); // Result of the last stepped cycle
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
